//--- list.f
+incdir+verif
rtl/fxp_pkg.sv
rtl/link_pkg.sv
rtl/req_ack_rx.sv
rtl/rshift.sv
rtl/sat_narrow.sv
rtl/req_ack_tx.sv
rtl/requant_top.sv
verif/requant_tb.sv

//--- Makefile
# Verilator build and run for the requantization stage

SHELL      := /bin/bash

VERILATOR  ?= verilator
TOP        ?= requant_tb
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SOURCES    := $(wildcard rtl/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	set -o pipefail; $(SIM_BIN) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/requant_vectors.svh
// ********************
// stimulus and expected-value table, fixed corner rows
// ********************
`ifndef REQUANT_VECTORS_SVH
`define REQUANT_VECTORS_SVH

localparam int NUM_FIXED  = 6;
localparam int NUM_RANDOM = 26;
localparam int NUM_ROWS   = NUM_FIXED + NUM_RANDOM;

// input vector, expected narrow data, expected flags; lane 0 in the low bits
in_vec_t   tbl_in   [NUM_ROWS];
data_vec_t tbl_data [NUM_ROWS];
flag_vec_t tbl_sat  [NUM_ROWS];

task automatic load_corner_rows();
    // positive, in range
    tbl_in[0]   = 128'h0123_0035_0000_07FF_07F0_0100_0020_0010;
    tbl_data[0] = 64'h12_03_00_7F_7F_10_02_01;
    tbl_sat[0]  = 8'h00;
    // negative, floored toward minus infinity
    tbl_in[1]   = 128'hFFE0_FFF1_FF00_F801_F800_FFEF_FFF0_FFFF;
    tbl_data[1] = 64'hFE_FF_F0_80_80_FE_FF_FF;
    tbl_sat[1]  = 8'h00;
    // mixed clamp, lanes 0 2 3 4 6 outside range
    tbl_in[2]   = 128'h07FF_080F_FFFF_8000_F7FF_7FFF_0010_0800;
    tbl_data[2] = 64'h7F_7F_FF_80_80_7F_01_7F;
    tbl_sat[2]  = 8'h5D;
    // full-scale positive
    tbl_in[3]   = {DEF_LANES{16'h7FFF}};
    tbl_data[3] = {DEF_LANES{8'h7F}};
    tbl_sat[3]  = 8'hFF;
    // full-scale negative
    tbl_in[4]   = {DEF_LANES{16'h8000}};
    tbl_data[4] = {DEF_LANES{8'h80}};
    tbl_sat[4]  = 8'hFF;
    tbl_in[5]   = '0;
    tbl_data[5] = '0;
    tbl_sat[5]  = '0;
endtask

`endif

//--- verif/requant_tb.sv
// ********************
// testbench for requant_top: host, sink, table loop, checks
// ********************
`timescale 1ns/100ps
`default_nettype none

module requant_tb
    import fxp_pkg::*;
();

    localparam int LANES = DEF_LANES;
    localparam int W_IN  = DEF_W_IN;
    localparam int W_OUT = DEF_W_OUT;
    localparam int SHIFT = DEF_SHIFT;

    typedef logic [LANES*W_IN-1:0]  in_vec_t;
    typedef logic [LANES*W_OUT-1:0] data_vec_t;
    typedef logic [LANES-1:0]       flag_vec_t;

    `include "requant_vectors.svh"

    localparam int TIMEOUT_CYCLES = NUM_ROWS * 24 + 200;

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      in_req = 1'b0;
    in_vec_t   in_data = '0;
    logic      in_ack;
    logic      out_req;
    data_vec_t out_data;
    flag_vec_t out_sat;
    logic      out_ack = 1'b0;

    integer seed = 32'he92e6007;
    int     cycles = 0;
    int     sent = 0;
    int     rcvd = 0;
    int     host_stalls = 0;
    int     max_in_flight = 0;
    int     pass_count = 0;
    int     fail_count = 0;

    requant_top #(.LANES(LANES), .W_IN(W_IN), .W_OUT(W_OUT), .SHIFT(SHIFT)) u_dut (
        .clk(clk), .rst_n(rst_n),
        .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
        .out_req(out_req), .out_data(out_data), .out_sat(out_sat), .out_ack(out_ack)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d vectors received",
                     cycles, rcvd, NUM_ROWS);
            $display("Testbench failed");
            $finish;
        end
    end

    // ******************** helpers
    task automatic next_cycle();
        @(posedge clk);
        #1; // drive and sample just after the edge
    endtask

    task automatic tally(input string name, input bit ok);
        $display("%s: %s", name, ok ? "ok" : "FAILED");
        if (ok) pass_count++;
        else fail_count++;
    endtask

    // floor(v / 2**SHIFT), clamped to the signed W_OUT range
    task automatic expect_lane(input int v, output logic [W_OUT-1:0] q_out,
                               output logic clamped);
        int div;
        int q;
        int hi;
        int lo;
        div = 1 << SHIFT;
        q   = v / div;
        if (v < 0 && (v % div) != 0) q = q - 1; // division rounds toward zero
        hi = (1 << (W_OUT - 1)) - 1;
        lo = -(1 << (W_OUT - 1));
        clamped = (q > hi) || (q < lo);
        if (q > hi) q = hi;
        else if (q < lo) q = lo;
        q_out = q[W_OUT-1:0];
    endtask

    task automatic fill_random_rows();
        int               v;
        logic [W_OUT-1:0] q;
        logic             c;
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            for (int l = 0; l < LANES; l++) begin
                v = $random(seed);
                v = (l % 2 == 0) ? v % 3000 : v % 32768; // even lanes near range
                tbl_in[r][l*W_IN +: W_IN] = v[W_IN-1:0];
                expect_lane(v, q, c);
                tbl_data[r][l*W_OUT +: W_OUT] = q;
                tbl_sat[r][l] = c;
            end
        end
    endtask

    // ******************** compare tasks
    task automatic check_data(input data_vec_t got, input data_vec_t exp,
                              input int row, inout bit ok);
        if (got !== exp) begin
            $display("error t=%0t out_data row %0d: got %h expected %h", $time, row, got, exp);
            ok = 1'b0;
        end
    endtask

    task automatic check_sat(input flag_vec_t got, input flag_vec_t exp,
                             input int row, inout bit ok);
        if (got !== exp) begin
            $display("error t=%0t out_sat row %0d: got %h expected %h", $time, row, got, exp);
            ok = 1'b0;
        end
    endtask

    // ******************** host and sink
    task automatic host_run();
        int waited;
        for (int r = 0; r < NUM_ROWS; r++) begin
            in_data = tbl_in[r];
            in_req  = 1'b1;
            waited  = 0;
            next_cycle();
            while (!in_ack) begin
                waited++;
                next_cycle();
            end
            if (waited > 0) host_stalls++; // held off by a full pipeline
            sent++;
            if (sent - rcvd > max_in_flight) max_in_flight = sent - rcvd;
            in_req = 1'b0;
            while (in_ack) next_cycle();
        end
    endtask

    task automatic sink_run();
        int delay;
        bit ok;
        for (int r = 0; r < NUM_ROWS; r++) begin
            while (!out_req) next_cycle();
            ok = 1'b1;
            check_data(out_data, tbl_data[r], r, ok);
            check_sat(out_sat, tbl_sat[r], r, ok);
            tally($sformatf("row %0d", r), ok);
            delay = $unsigned($random(seed)) % 9;
            repeat (delay) next_cycle();
            out_ack = 1'b1;
            while (out_req) next_cycle();
            out_ack = 1'b0;
            rcvd++;
        end
    endtask

    // ******************** main sequence
    initial begin
        bit ok;
        ok = 1'b1;
        load_corner_rows();
        fill_random_rows();
        repeat (16) begin
            next_cycle();
            if (in_ack !== 1'b0 || out_req !== 1'b0) ok = 1'b0;
        end
        rst_n = 1'b1;
        next_cycle();
        if (in_ack !== 1'b0 || out_req !== 1'b0) ok = 1'b0;
        tally("reset: handshake outputs low", ok);

        fork
            host_run();
            sink_run();
        join

        tally($sformatf("back-pressure: %0d host stalls, %0d in flight",
                        host_stalls, max_in_flight),
              host_stalls > 0 && max_in_flight >= 3);

        ok = 1'b1;
        repeat (20) begin
            next_cycle();
            if (out_req !== 1'b0) ok = 1'b0; // a repeated or stray vector
        end
        tally("no extra vectors after the last row", ok);

        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/requant_top.sv
// ********************
// requantization top, rx -> shift -> saturate -> tx
// ********************
`timescale 1ns/100ps
`default_nettype none

module requant_top
    import fxp_pkg::*;
#(
    parameter int LANES = DEF_LANES,
    parameter int W_IN  = DEF_W_IN,
    parameter int W_OUT = DEF_W_OUT,
    parameter int SHIFT = DEF_SHIFT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_req,
    input  logic [LANES*W_IN-1:0]  in_data,
    output logic                   in_ack,
    output logic                   out_req,
    output logic [LANES*W_OUT-1:0] out_data,
    output logic [LANES-1:0]       out_sat,
    input  logic                   out_ack
);

    typedef logic [vec_bits(LANES, W_IN)-1:0] in_vec_t;

    // flags sit above the data in the packed beat
    typedef struct packed {
        logic [LANES-1:0]                  sat;
        logic [vec_bits(LANES, W_OUT)-1:0] data;
    } out_beat_t;

    in_vec_t                rx_data;
    logic                   rx_valid, rx_ready;
    logic [LANES*W_IN-1:0]  sh_data;
    logic                   sh_valid, sh_ready;
    logic [LANES*W_OUT-1:0] sat_data;
    logic [LANES-1:0]       sat_flags;
    logic                   sat_valid, sat_ready;
    out_beat_t              tx_beat;
    out_beat_t              out_beat;

    req_ack_rx #(.payload_t(in_vec_t)) u_rx (
        .clk(clk), .rst_n(rst_n),
        .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
        .m_valid(rx_valid), .m_data(rx_data), .m_ready(rx_ready)
    );

    rshift #(.LANES(LANES), .W_IN(W_IN), .SHIFT(SHIFT)) u_shift (
        .clk(clk), .rst_n(rst_n),
        .s_valid(rx_valid), .s_data(rx_data), .s_ready(rx_ready),
        .m_valid(sh_valid), .m_data(sh_data), .m_ready(sh_ready)
    );

    sat_narrow #(.LANES(LANES), .W_IN(W_IN), .W_OUT(W_OUT)) u_sat (
        .clk(clk), .rst_n(rst_n),
        .s_valid(sh_valid), .s_data(sh_data), .s_ready(sh_ready),
        .m_valid(sat_valid), .m_data(sat_data), .m_sat(sat_flags),
        .m_ready(sat_ready)
    );

    assign tx_beat = '{sat: sat_flags, data: sat_data};

    req_ack_tx #(.payload_t(out_beat_t)) u_tx (
        .clk(clk), .rst_n(rst_n),
        .s_valid(sat_valid), .s_data(tx_beat), .s_ready(sat_ready),
        .out_req(out_req), .out_data(out_beat), .out_ack(out_ack)
    );

    // split the beat at the boundary
    assign out_data = out_beat.data;
    assign out_sat  = out_beat.sat;

endmodule

`default_nettype wire

//--- rtl/req_ack_tx.sv
// ********************
// four-phase transmitter fed by valid/ready
// ********************
`timescale 1ns/100ps
`default_nettype none

module req_ack_tx
    import link_pkg::*;
#(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     s_valid,
    input  payload_t s_data,
    output logic     s_ready,
    output logic     out_req,
    output payload_t out_data,
    input  logic     out_ack
);

    tx_state_t state;
    payload_t  hold;

    assign s_ready  = (state == tx_idle);
    assign out_req  = (state == tx_req);
    assign out_data = hold;

    // ******************** offer fsm
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= tx_idle;
        end else begin
            case (state)
                tx_idle: begin
                    if (s_valid) begin
                        state <= tx_req;
                    end
                end
                tx_req: begin
                    if (out_ack) begin
                        state <= tx_drop;
                    end
                end
                tx_drop: begin
                    if (!out_ack) begin
                        state <= tx_idle; // sink finished its phase
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            hold <= s_data;
        end
    end

    // ******************** sink protocol checks
    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_ack) |-> out_req)
        else $error("req_ack_tx: out_ack rose without out_req");

    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_req && $past(out_req)) |-> $stable(out_data))
        else $error("req_ack_tx: out_data changed during offer");

endmodule

`default_nettype wire

//--- rtl/sat_narrow.sv
// ********************
// registered per-lane saturation to narrow width, with flags
// ********************
`timescale 1ns/100ps
`default_nettype none

module sat_narrow
    import fxp_pkg::*;
#(
    parameter int LANES = 8,
    parameter int W_IN  = 16,
    parameter int W_OUT = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   s_valid,
    input  logic [LANES*W_IN-1:0]  s_data,
    output logic                   s_ready,
    output logic                   m_valid,
    output logic [LANES*W_OUT-1:0] m_data,
    output logic [LANES-1:0]       m_sat,
    input  logic                   m_ready
);

    // narrow signed limits, sign-extended to the input width
    localparam logic signed [W_IN-1:0] SAT_MAX =
        {{(W_IN-W_OUT+1){1'b0}}, {(W_OUT-1){1'b1}}};
    localparam logic signed [W_IN-1:0] SAT_MIN =
        {{(W_IN-W_OUT+1){1'b1}}, {(W_OUT-1){1'b0}}};

    logic [LANES*W_OUT-1:0] narrow;
    logic [LANES-1:0]       sat_flag;
    logic                   take;

    if (W_OUT > W_IN) begin : g_width_chk
        $fatal(1, "sat_narrow: W_OUT (%0d) exceeds W_IN (%0d)", W_OUT, W_IN);
    end

    // ******************** clamp
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic signed [W_IN-1:0] lane;
        logic                   over;
        logic                   under;

        assign lane        = $signed(s_data[lane_lo(i, W_IN) +: W_IN]);
        assign over        = lane > SAT_MAX;
        assign under       = lane < SAT_MIN;
        assign sat_flag[i] = over || under;
        assign narrow[lane_lo(i, W_OUT) +: W_OUT] =
            over  ? SAT_MAX[W_OUT-1:0] :
            under ? SAT_MIN[W_OUT-1:0] :
                    lane[W_OUT-1:0];    // in range, drop upper bits
    end

    assign s_ready = !m_valid || m_ready;
    assign take    = s_valid && s_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (take) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_data <= narrow;
            m_sat  <= sat_flag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rshift.sv
// ********************
// registered per-lane arithmetic right shift
// ********************
`timescale 1ns/100ps
`default_nettype none

module rshift
    import fxp_pkg::*;
#(
    parameter int LANES = 8,
    parameter int W_IN  = 16,
    parameter int SHIFT = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  s_valid,
    input  logic [LANES*W_IN-1:0] s_data,
    output logic                  s_ready,
    output logic                  m_valid,
    output logic [LANES*W_IN-1:0] m_data,
    input  logic                  m_ready
);

    logic [LANES*W_IN-1:0] shifted;
    logic                  take;

    // floor division by 2**SHIFT, sign bit replicated in
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign shifted[lane_lo(i, W_IN) +: W_IN] =
            $signed(s_data[lane_lo(i, W_IN) +: W_IN]) >>> SHIFT;
    end

    assign s_ready = !m_valid || m_ready; // empty or draining this edge
    assign take    = s_valid && s_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (take) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_data <= shifted;
        end
    end

    // ******************** stall check
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (m_valid && !m_ready) |=> $stable(m_data))
        else $error("rshift: output changed under stall");

endmodule

`default_nettype wire

//--- rtl/req_ack_rx.sv
// ********************
// four-phase receiver with valid/ready output
// ********************
`timescale 1ns/100ps
`default_nettype none

module req_ack_rx
    import link_pkg::*;
#(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_req,
    input  payload_t in_data,
    output logic     in_ack,
    output logic     m_valid,
    output payload_t m_data,
    input  logic     m_ready
);

    rx_state_t state;
    logic      load;

    // only start a new handshake once the holding register drained
    assign load   = (state == rx_idle) && in_req && !m_valid;
    assign in_ack = (state == rx_ack);

    // ******************** handshake fsm
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= rx_idle;
            m_valid <= 1'b0;
        end else begin
            case (state)
                rx_idle: begin
                    if (load) begin
                        state <= rx_ack;
                    end
                end
                rx_ack: begin
                    if (!in_req) begin
                        state <= rx_idle; // ack drops next cycle
                    end
                end
                default: state <= rx_idle;
            endcase

            if (load) begin
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_data <= in_data; // holding register
        end
    end

    // ******************** host protocol checks
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (in_req && !in_ack) |=> (in_req || in_ack))
        else $error("req_ack_rx: in_req dropped before in_ack");

    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (in_req && !in_ack) |=> (in_ack || $stable(in_data)))
        else $error("req_ack_rx: in_data changed while waiting for ack");

endmodule

`default_nettype wire

//--- rtl/link_pkg.sv
// ********************
// handshake state encodings for rx and tx
// ********************
`default_nettype none

package link_pkg;

    // receiver side of four-phase req/ack
    typedef enum logic [1:0] {
        rx_idle = 2'd0, // waiting for in_req
        rx_ack  = 2'd1  // ack high, waiting for in_req to drop
    } rx_state_t;

    // transmitter side
    typedef enum logic [1:0] {
        tx_idle = 2'd0, // nothing offered
        tx_req  = 2'd1, // out_req high, waiting for out_ack
        tx_drop = 2'd2  // out_req low, waiting for out_ack to drop
    } tx_state_t;

endpackage

`default_nettype wire

//--- rtl/fxp_pkg.sv
// ********************
// fixed-point format defaults and lane geometry helpers
// ********************
`default_nettype none

package fxp_pkg;

    // ******************** number format
    localparam int DEF_LANES    = 8;
    localparam int DEF_W_IN     = 16;
    localparam int DEF_FRAC_IN  = 8;
    localparam int DEF_W_OUT    = 8;
    localparam int DEF_FRAC_OUT = 4;
    localparam int DEF_SHIFT    = DEF_FRAC_IN - DEF_FRAC_OUT;

    // ******************** lane geometry
    // lane 0 occupies the least significant bits
    function automatic int vec_bits(input int lanes, input int width);
        return lanes * width;
    endfunction

    function automatic int lane_lo(input int idx, input int width);
        return idx * width; // low bit of lane idx
    endfunction

endpackage

`default_nettype wire
